//--- filelist.f
hdl/cpu_pkg.sv
hdl/id_ex.sv
hdl/alu_exec.sv
hdl/ex_mem.sv
hdl/data_mem.sv
hdl/mem_wb.sv
hdl/backend_top.sv
tests/backend_assert.sv
tests/backend_tb.sv

//--- hdl/alu_exec.sv
`timescale 1ns/1ps

module alu_exec (
    input  logic             ex_alu_src,
    input  cpu_pkg::alu_op_t ex_alu_op,
    input  cpu_pkg::word_t   ex_reg1_data,
    input  cpu_pkg::word_t   ex_reg2_data,
    input  cpu_pkg::word_t   ex_imm,
    output cpu_pkg::word_t   ex_alu_out
);

    import cpu_pkg::*;

    word_t      op_a;
    word_t      op_b;
    logic [3:0] shamt;

    assign op_a  = ex_reg1_data;
    assign op_b  = ex_alu_src ? ex_imm : ex_reg2_data;  // immediate forms
    assign shamt = op_b[3:0];

    // all results wrap at the word width
    always_comb begin
        ex_alu_out = op_b;
        case (ex_alu_op)
            ALU_ADD: begin
                ex_alu_out = op_a + op_b;
            end
            ALU_SUB: begin
                ex_alu_out = op_a - op_b;
            end
            ALU_AND: begin
                ex_alu_out = op_a & op_b;
            end
            ALU_OR: begin
                ex_alu_out = op_a | op_b;
            end
            ALU_XOR: begin
                ex_alu_out = op_a ^ op_b;
            end
            ALU_SLL: begin
                ex_alu_out = op_a << shamt;
            end
            ALU_SRL: begin
                ex_alu_out = op_a >> shamt;  // no sign fill
            end
            ALU_PASSB: begin
                ex_alu_out = op_b;           // effective address passes through
            end
            default: begin
                ex_alu_out = op_b;
            end
        endcase
    end

endmodule

//--- hdl/backend_top.sv
`timescale 1ns/1ps

module backend_top #(
    parameter int MEM_ADDR_W = 8
) (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              id_mem_read,
    input  logic              id_mem_write,
    input  logic              id_reg_write,
    input  logic              id_createdump,
    input  logic              id_halt,
    input  logic              id_alu_src,
    input  cpu_pkg::alu_op_t  id_alu_op,
    input  cpu_pkg::wb_sel_t  id_mem_to_reg,
    input  cpu_pkg::reg_idx_t id_write_reg,
    input  cpu_pkg::word_t    id_reg1_data,
    input  cpu_pkg::word_t    id_reg2_data,
    input  cpu_pkg::word_t    id_imm,
    input  cpu_pkg::word_t    id_pc_plus,
    output logic              wb_reg_write,
    output cpu_pkg::reg_idx_t wb_write_reg,
    output cpu_pkg::word_t    wb_data,
    output logic              wb_halt,
    output logic              wb_createdump
);

    import cpu_pkg::*;

    // execute stage
    logic     ex_mem_read, ex_mem_write, ex_reg_write, ex_createdump, ex_halt, ex_alu_src;
    alu_op_t  ex_alu_op;
    wb_sel_t  ex_mem_to_reg;
    reg_idx_t ex_write_reg;
    word_t    ex_reg1_data, ex_reg2_data, ex_imm, ex_pc_plus, ex_alu_out;

    // memory stage
    logic     mem_mem_read, mem_mem_write, mem_reg_write, mem_createdump, mem_halt;
    wb_sel_t  mem_mem_to_reg;
    reg_idx_t mem_write_reg;
    word_t    mem_alu_out, mem_pc_plus, mem_reg2_data, mem_imm;

    word_t    wb_mem_data;  // registered load data

    id_ex i_id_ex (
        .clk(clk), .rst_n(rst_n),
        .id_mem_read(id_mem_read), .id_mem_write(id_mem_write),
        .id_reg_write(id_reg_write), .id_createdump(id_createdump),
        .id_halt(id_halt), .id_alu_src(id_alu_src), .id_alu_op(id_alu_op),
        .id_mem_to_reg(id_mem_to_reg), .id_write_reg(id_write_reg),
        .id_reg1_data(id_reg1_data), .id_reg2_data(id_reg2_data),
        .id_imm(id_imm), .id_pc_plus(id_pc_plus),
        .ex_mem_read(ex_mem_read), .ex_mem_write(ex_mem_write),
        .ex_reg_write(ex_reg_write), .ex_createdump(ex_createdump),
        .ex_halt(ex_halt), .ex_alu_src(ex_alu_src), .ex_alu_op(ex_alu_op),
        .ex_mem_to_reg(ex_mem_to_reg), .ex_write_reg(ex_write_reg),
        .ex_reg1_data(ex_reg1_data), .ex_reg2_data(ex_reg2_data),
        .ex_imm(ex_imm), .ex_pc_plus(ex_pc_plus)
    );

    alu_exec i_alu_exec (
        .ex_alu_src(ex_alu_src), .ex_alu_op(ex_alu_op),
        .ex_reg1_data(ex_reg1_data), .ex_reg2_data(ex_reg2_data),
        .ex_imm(ex_imm), .ex_alu_out(ex_alu_out)
    );

    ex_mem i_ex_mem (
        .clk(clk), .rst_n(rst_n),
        .ex_mem_read(ex_mem_read), .ex_mem_write(ex_mem_write),
        .ex_reg_write(ex_reg_write), .ex_createdump(ex_createdump),
        .ex_halt(ex_halt), .ex_mem_to_reg(ex_mem_to_reg),
        .ex_write_reg(ex_write_reg), .ex_alu_out(ex_alu_out),
        .ex_pc_plus(ex_pc_plus), .ex_reg2_data(ex_reg2_data), .ex_imm(ex_imm),
        .mem_mem_read(mem_mem_read), .mem_mem_write(mem_mem_write),
        .mem_reg_write(mem_reg_write), .mem_createdump(mem_createdump),
        .mem_halt(mem_halt), .mem_mem_to_reg(mem_mem_to_reg),
        .mem_write_reg(mem_write_reg), .mem_alu_out(mem_alu_out),
        .mem_pc_plus(mem_pc_plus), .mem_reg2_data(mem_reg2_data), .mem_imm(mem_imm)
    );

    data_mem #(
        .MEM_ADDR_W(MEM_ADDR_W)
    ) i_data_mem (
        .clk(clk),
        .mem_mem_read(mem_mem_read), .mem_mem_write(mem_mem_write),
        .mem_alu_out(mem_alu_out), .mem_reg2_data(mem_reg2_data),
        .wb_mem_data(wb_mem_data)
    );

    mem_wb i_mem_wb (
        .clk(clk), .rst_n(rst_n),
        .mem_reg_write(mem_reg_write), .mem_createdump(mem_createdump),
        .mem_halt(mem_halt), .mem_mem_to_reg(mem_mem_to_reg),
        .mem_write_reg(mem_write_reg), .mem_alu_out(mem_alu_out),
        .mem_pc_plus(mem_pc_plus), .mem_imm(mem_imm), .wb_mem_data(wb_mem_data),
        .wb_reg_write(wb_reg_write), .wb_write_reg(wb_write_reg),
        .wb_data(wb_data), .wb_halt(wb_halt), .wb_createdump(wb_createdump)
    );

endmodule

//--- hdl/cpu_pkg.sv
package cpu_pkg;

    // data path and memory word
    typedef logic [15:0] word_t;

    // destination register index, eight registers
    typedef logic [2:0] reg_idx_t;

    typedef logic [2:0] alu_op_t;

    // memToReg in the older stage naming
    typedef logic [1:0] wb_sel_t;

    localparam alu_op_t ALU_ADD   = 3'd0;
    localparam alu_op_t ALU_SUB   = 3'd1;  // a minus b
    localparam alu_op_t ALU_AND   = 3'd2;
    localparam alu_op_t ALU_OR    = 3'd3;
    localparam alu_op_t ALU_XOR   = 3'd4;
    localparam alu_op_t ALU_SLL   = 3'd5;  // shift amount from b[3:0]
    localparam alu_op_t ALU_SRL   = 3'd6;  // logical, zero fill
    localparam alu_op_t ALU_PASSB = 3'd7;  // address-only forms

    localparam wb_sel_t WB_ALU = 2'd0;
    localparam wb_sel_t WB_MEM = 2'd1;
    localparam wb_sel_t WB_PC  = 2'd2;     // link value
    localparam wb_sel_t WB_IMM = 2'd3;     // sign-extended immediate

endpackage

//--- hdl/data_mem.sv
`timescale 1ns/1ps

module data_mem #(
    parameter int MEM_ADDR_W = 8
) (
    input  logic           clk,
    input  logic           mem_mem_read,
    input  logic           mem_mem_write,
    input  cpu_pkg::word_t mem_alu_out,
    input  cpu_pkg::word_t mem_reg2_data,
    output cpu_pkg::word_t wb_mem_data
);

    import cpu_pkg::*;

    localparam int DEPTH = 1 << MEM_ADDR_W;

    word_t                 mem [DEPTH];
    logic [MEM_ADDR_W-1:0] addr;

    assign addr = mem_alu_out[MEM_ADDR_W-1:0];  // word address, upper bits ignored

    // store lands at the edge closing its MEM cycle
    always_ff @(posedge clk) begin
        if (mem_mem_write) begin
            mem[addr] <= mem_reg2_data;
        end
    end

    // registered read, lines up with the mem_wb capture
    always_ff @(posedge clk) begin
        if (mem_mem_read) begin
            wb_mem_data <= mem[addr];
        end
    end

endmodule

//--- hdl/ex_mem.sv
`timescale 1ns/1ps

module ex_mem (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              ex_mem_read,
    input  logic              ex_mem_write,
    input  logic              ex_reg_write,
    input  logic              ex_createdump,
    input  logic              ex_halt,
    input  cpu_pkg::wb_sel_t  ex_mem_to_reg,
    input  cpu_pkg::reg_idx_t ex_write_reg,
    input  cpu_pkg::word_t    ex_alu_out,
    input  cpu_pkg::word_t    ex_pc_plus,
    input  cpu_pkg::word_t    ex_reg2_data,
    input  cpu_pkg::word_t    ex_imm,
    output logic              mem_mem_read,
    output logic              mem_mem_write,
    output logic              mem_reg_write,
    output logic              mem_createdump,
    output logic              mem_halt,
    output cpu_pkg::wb_sel_t  mem_mem_to_reg,
    output cpu_pkg::reg_idx_t mem_write_reg,
    output cpu_pkg::word_t    mem_alu_out,
    output cpu_pkg::word_t    mem_pc_plus,
    output cpu_pkg::word_t    mem_reg2_data,
    output cpu_pkg::word_t    mem_imm
);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mem_mem_read   <= 1'b0;
            mem_mem_write  <= 1'b0;  // no stray store out of reset
            mem_reg_write  <= 1'b0;
            mem_createdump <= 1'b0;
            mem_halt       <= 1'b0;
            mem_mem_to_reg <= '0;
            mem_write_reg  <= '0;
            mem_alu_out    <= '0;
            mem_pc_plus    <= '0;
            mem_reg2_data  <= '0;
            mem_imm        <= '0;
        end else begin
            mem_mem_read   <= ex_mem_read;
            mem_mem_write  <= ex_mem_write;
            mem_reg_write  <= ex_reg_write;
            mem_createdump <= ex_createdump;
            mem_halt       <= ex_halt;
            mem_mem_to_reg <= ex_mem_to_reg;
            mem_write_reg  <= ex_write_reg;
            mem_alu_out    <= ex_alu_out;    // address for data_mem
            mem_pc_plus    <= ex_pc_plus;
            mem_reg2_data  <= ex_reg2_data;  // store data
            mem_imm        <= ex_imm;
        end
    end

endmodule

//--- hdl/id_ex.sv
`timescale 1ns/1ps

module id_ex (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              id_mem_read,
    input  logic              id_mem_write,
    input  logic              id_reg_write,
    input  logic              id_createdump,
    input  logic              id_halt,
    input  logic              id_alu_src,
    input  cpu_pkg::alu_op_t  id_alu_op,
    input  cpu_pkg::wb_sel_t  id_mem_to_reg,
    input  cpu_pkg::reg_idx_t id_write_reg,
    input  cpu_pkg::word_t    id_reg1_data,
    input  cpu_pkg::word_t    id_reg2_data,
    input  cpu_pkg::word_t    id_imm,
    input  cpu_pkg::word_t    id_pc_plus,
    output logic              ex_mem_read,
    output logic              ex_mem_write,
    output logic              ex_reg_write,
    output logic              ex_createdump,
    output logic              ex_halt,
    output logic              ex_alu_src,
    output cpu_pkg::alu_op_t  ex_alu_op,
    output cpu_pkg::wb_sel_t  ex_mem_to_reg,
    output cpu_pkg::reg_idx_t ex_write_reg,
    output cpu_pkg::word_t    ex_reg1_data,
    output cpu_pkg::word_t    ex_reg2_data,
    output cpu_pkg::word_t    ex_imm,
    output cpu_pkg::word_t    ex_pc_plus
);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ex_mem_read   <= 1'b0;  // reset looks like a bubble
            ex_mem_write  <= 1'b0;
            ex_reg_write  <= 1'b0;
            ex_createdump <= 1'b0;
            ex_halt       <= 1'b0;
            ex_alu_src    <= 1'b0;
            ex_alu_op     <= '0;
            ex_mem_to_reg <= '0;
            ex_write_reg  <= '0;
            ex_reg1_data  <= '0;
            ex_reg2_data  <= '0;
            ex_imm        <= '0;
            ex_pc_plus    <= '0;
        end else begin
            ex_mem_read   <= id_mem_read;
            ex_mem_write  <= id_mem_write;
            ex_reg_write  <= id_reg_write;
            ex_createdump <= id_createdump;
            ex_halt       <= id_halt;
            ex_alu_src    <= id_alu_src;
            ex_alu_op     <= id_alu_op;
            ex_mem_to_reg <= id_mem_to_reg;
            ex_write_reg  <= id_write_reg;
            ex_reg1_data  <= id_reg1_data;
            ex_reg2_data  <= id_reg2_data;  // also the store data later
            ex_imm        <= id_imm;
            ex_pc_plus    <= id_pc_plus;
        end
    end

endmodule

//--- hdl/mem_wb.sv
`timescale 1ns/1ps

module mem_wb (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              mem_reg_write,
    input  logic              mem_createdump,
    input  logic              mem_halt,
    input  cpu_pkg::wb_sel_t  mem_mem_to_reg,
    input  cpu_pkg::reg_idx_t mem_write_reg,
    input  cpu_pkg::word_t    mem_alu_out,
    input  cpu_pkg::word_t    mem_pc_plus,
    input  cpu_pkg::word_t    mem_imm,
    input  cpu_pkg::word_t    wb_mem_data,
    output logic              wb_reg_write,
    output cpu_pkg::reg_idx_t wb_write_reg,
    output cpu_pkg::word_t    wb_data,
    output logic              wb_halt,
    output logic              wb_createdump
);

    import cpu_pkg::*;

    wb_sel_t wb_mem_to_reg;
    word_t   wb_alu_out;
    word_t   wb_pc_plus;
    word_t   wb_imm;

    // memory data is already registered inside data_mem
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wb_reg_write  <= 1'b0;
            wb_write_reg  <= '0;
            wb_halt       <= 1'b0;
            wb_createdump <= 1'b0;
            wb_mem_to_reg <= '0;
            wb_alu_out    <= '0;
            wb_pc_plus    <= '0;
            wb_imm        <= '0;
        end else begin
            wb_reg_write  <= mem_reg_write;
            wb_write_reg  <= mem_write_reg;
            wb_halt       <= mem_halt;
            wb_createdump <= mem_createdump;
            wb_mem_to_reg <= mem_mem_to_reg;
            wb_alu_out    <= mem_alu_out;
            wb_pc_plus    <= mem_pc_plus;
            wb_imm        <= mem_imm;
        end
    end

    always_comb begin
        case (wb_mem_to_reg)
            WB_MEM:  wb_data = wb_mem_data;
            WB_PC:   wb_data = wb_pc_plus;  // link register value
            WB_IMM:  wb_data = wb_imm;
            default: wb_data = wb_alu_out;  // WB_ALU
        endcase
    end

endmodule

//--- run.sh
#!/bin/sh
# build and run the backend testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f filelist.f --top-module backend_tb

# the simulator may exit non-zero on a failure, the log decides
./obj_dir/Vbackend_tb > sim.log 2>&1 || true
cat sim.log

if grep -q "Test failed" sim.log; then
    echo "simulation FAILED"
    exit 1
fi
if ! grep -q "Test passed" sim.log; then
    echo "simulation ended without a result"
    exit 1
fi
echo "simulation PASSED"

//--- tests/backend_assert.sv
`timescale 1ns/1ps

module backend_assert (
    input logic              clk,
    input logic              rst_n,
    input logic              id_reg_write,
    input logic              id_halt,
    input logic              id_createdump,
    input cpu_pkg::reg_idx_t id_write_reg,
    input logic              wb_reg_write,
    input cpu_pkg::reg_idx_t wb_write_reg,
    input logic              wb_halt,
    input logic              wb_createdump
);

    // first three edges after release still show reset state
    reset_quiet: assert property (@(posedge clk)
        (rst_n && !($past(rst_n, 1) && $past(rst_n, 2) && $past(rst_n, 3)))
        |-> (!wb_reg_write && !wb_halt && !wb_createdump))
        else $error("wb flags active while reset state drains");

    write_reg_latency: assert property (@(posedge clk)
        ($past(rst_n, 1) && $past(rst_n, 2) && $past(rst_n, 3))
        |-> (wb_write_reg == $past(id_write_reg, 3)))
        else $error("wb_write_reg does not match id_write_reg three cycles earlier");

    reg_write_latency: assert property (@(posedge clk)
        ($past(rst_n, 1) && $past(rst_n, 2) && $past(rst_n, 3))
        |-> (wb_reg_write == $past(id_reg_write, 3)))
        else $error("wb_reg_write does not match id_reg_write three cycles earlier");

    halt_latency: assert property (@(posedge clk)
        ($past(rst_n, 1) && $past(rst_n, 2) && $past(rst_n, 3))
        |-> (wb_halt == $past(id_halt, 3)))
        else $error("wb_halt does not match id_halt three cycles earlier");

    createdump_latency: assert property (@(posedge clk)
        ($past(rst_n, 1) && $past(rst_n, 2) && $past(rst_n, 3))
        |-> (wb_createdump == $past(id_createdump, 3)))
        else $error("wb_createdump does not match id_createdump three cycles earlier");

endmodule

bind backend_top backend_assert i_backend_assert (
    .clk(clk), .rst_n(rst_n),
    .id_reg_write(id_reg_write), .id_halt(id_halt),
    .id_createdump(id_createdump), .id_write_reg(id_write_reg),
    .wb_reg_write(wb_reg_write), .wb_write_reg(wb_write_reg),
    .wb_halt(wb_halt), .wb_createdump(wb_createdump)
);

//--- tests/backend_tb.sv
`timescale 1ns/1ps

module backend_tb;

    import cpu_pkg::*;

    localparam int ALU_RPT        = 4;
    localparam int N_RESET_BUB    = 4;
    localparam int N_ALU          = 8 * 2 * ALU_RPT;  // every op with both operand-B sources
    localparam int N_FILL         = 16;
    localparam int N_LOAD         = 16;
    localparam int N_PAIR         = 8;
    localparam int N_WB_OTHER     = 16;
    localparam int N_FLAGS        = 16;
    localparam int LAG            = 4;  // queue depth when the oldest entry sits in wb
    localparam int N_TOTAL        = N_RESET_BUB + N_ALU + N_FILL + N_LOAD + 2 * N_PAIR
                                    + N_WB_OTHER + N_FLAGS + (LAG - 1);
    localparam int TIMEOUT_CYCLES = 10 + N_TOTAL + 20;

    typedef struct packed {
        logic     reg_write;
        logic     halt;
        logic     createdump;
        logic     check_data;
        reg_idx_t write_reg;
        word_t    data;
    } wb_exp_t;

    logic     clk;
    logic     rst_n;
    logic     id_mem_read, id_mem_write, id_reg_write, id_createdump, id_halt, id_alu_src;
    alu_op_t  id_alu_op;
    wb_sel_t  id_mem_to_reg;
    reg_idx_t id_write_reg;
    word_t    id_reg1_data, id_reg2_data, id_imm, id_pc_plus;
    logic     wb_reg_write, wb_halt, wb_createdump;
    reg_idx_t wb_write_reg;
    word_t    wb_data;

    integer  seed = 32'h5be9_77c3;
    int      mem_aw;
    word_t   shadow [];      // model of the data memory
    wb_exp_t exp_q [$];
    string   name_q [$];
    int      cycle_cnt = 0;
    logic    reset_done = 1'b0;

    backend_top i_backend_top (
        .clk(clk), .rst_n(rst_n),
        .id_mem_read(id_mem_read), .id_mem_write(id_mem_write),
        .id_reg_write(id_reg_write), .id_createdump(id_createdump),
        .id_halt(id_halt), .id_alu_src(id_alu_src), .id_alu_op(id_alu_op),
        .id_mem_to_reg(id_mem_to_reg), .id_write_reg(id_write_reg),
        .id_reg1_data(id_reg1_data), .id_reg2_data(id_reg2_data),
        .id_imm(id_imm), .id_pc_plus(id_pc_plus),
        .wb_reg_write(wb_reg_write), .wb_write_reg(wb_write_reg),
        .wb_data(wb_data), .wb_halt(wb_halt), .wb_createdump(wb_createdump)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Test failed");
            $fatal(1, "timeout");
        end
    end

    function automatic word_t rand_word();
        return word_t'($random(seed));
    endfunction

    function automatic reg_idx_t rand_reg();
        return reg_idx_t'($random(seed));
    endfunction

    function automatic alu_op_t rand_op();
        return alu_op_t'($random(seed));
    endfunction

    function automatic logic rand_bit();
        logic [31:0] r;
        r = $random(seed);
        return r[0];
    endfunction

    function automatic word_t alu_ref(alu_op_t op, word_t a, word_t b);
        case (op)
            ALU_ADD: return a + b;
            ALU_SUB: return a - b;
            ALU_AND: return a & b;
            ALU_OR:  return a | b;
            ALU_XOR: return a ^ b;
            ALU_SLL: return a << b[3:0];
            ALU_SRL: return a >> b[3:0];
            default: return b;  // pass operand B
        endcase
    endfunction

    task automatic report_mismatch(input string test, input word_t exp_val, input word_t act_val);
        $display("[ERROR] %s: expected %h, actual %h", test, exp_val, act_val);
        $display("Test failed");
        $fatal(1, "writeback mismatch");
    endtask

    // drives one instruction and queues its expected writeback
    task automatic drive_instr(input string test, input logic rd, input logic wr,
                               input logic rw, input logic hlt, input logic cd,
                               input logic src, input alu_op_t op, input wb_sel_t sel,
                               input reg_idx_t wreg, input word_t r1, input word_t r2,
                               input word_t imm, input word_t pc);
        wb_exp_t e;
        word_t   b;
        word_t   res;
        int      addr;
        b    = src ? imm : r2;
        res  = alu_ref(op, r1, b);
        addr = int'(res) & ((1 << mem_aw) - 1);  // word address from low bits
        e.reg_write  = rw;
        e.halt       = hlt;
        e.createdump = cd;
        e.write_reg  = wreg;
        e.check_data = rw;
        case (sel)
            WB_MEM:  e.data = shadow[addr];
            WB_PC:   e.data = pc;
            WB_IMM:  e.data = imm;
            default: e.data = res;
        endcase
        if (wr) begin
            shadow[addr] = r2;
        end
        @(posedge clk);
        exp_q.push_back(e);
        name_q.push_back(test);
        id_mem_read   <= rd;
        id_mem_write  <= wr;
        id_reg_write  <= rw;
        id_halt       <= hlt;
        id_createdump <= cd;
        id_alu_src    <= src;
        id_alu_op     <= op;
        id_mem_to_reg <= sel;
        id_write_reg  <= wreg;
        id_reg1_data  <= r1;
        id_reg2_data  <= r2;
        id_imm        <= imm;
        id_pc_plus    <= pc;
    endtask

    task automatic drive_bubble(input string test);
        drive_instr(test, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, ALU_ADD, WB_ALU, 3'd0,
                    16'h0, 16'h0, 16'h0, 16'h0);
    endtask

    // base plus offset lands on addr with junk above the address bits
    task automatic drive_mem_op(input string test, input logic is_store, input int addr,
                                input word_t val);
        word_t base;
        word_t imm;
        base = rand_word();
        imm  = word_t'(addr) - base + (rand_word() << mem_aw);
        drive_instr(test, !is_store, is_store, !is_store, 1'b0, 1'b0, 1'b1, ALU_ADD,
                    is_store ? WB_ALU : WB_MEM, rand_reg(), base, val, imm, rand_word());
    endtask

    always @(negedge clk) begin
        wb_exp_t e;
        string   test;
        if (reset_done) begin
            if (exp_q.size() >= LAG) begin
                e    = exp_q.pop_front();
                test = name_q.pop_front();
                assert (wb_reg_write == e.reg_write)
                    else report_mismatch({test, " reg_write"}, 16'(e.reg_write),
                                         16'(wb_reg_write));
                assert (wb_write_reg == e.write_reg)
                    else report_mismatch({test, " write_reg"}, 16'(e.write_reg),
                                         16'(wb_write_reg));
                assert (wb_halt == e.halt)
                    else report_mismatch({test, " halt"}, 16'(e.halt), 16'(wb_halt));
                assert (wb_createdump == e.createdump)
                    else report_mismatch({test, " createdump"}, 16'(e.createdump),
                                         16'(wb_createdump));
                if (e.check_data) begin
                    assert (wb_data == e.data)
                        else report_mismatch({test, " data"}, e.data, wb_data);
                end
            end else begin
                // still the reset state or the idle bubble
                assert (!wb_reg_write && !wb_halt && !wb_createdump && wb_write_reg == 3'd0)
                    else report_mismatch("reset", 16'h0,
                                         {10'h0, wb_write_reg, wb_reg_write, wb_halt,
                                          wb_createdump});
            end
        end
    end

    initial begin
        int addr;
        int fill_list [$];
        rst_n         = 1'b0;
        id_mem_read   = 1'b0;
        id_mem_write  = 1'b0;
        id_reg_write  = 1'b0;
        id_createdump = 1'b0;
        id_halt       = 1'b0;
        id_alu_src    = 1'b0;
        id_alu_op     = ALU_ADD;
        id_mem_to_reg = WB_ALU;
        id_write_reg  = 3'd0;
        id_reg1_data  = 16'h0;
        id_reg2_data  = 16'h0;
        id_imm        = 16'h0;
        id_pc_plus    = 16'h0;
        mem_aw = i_backend_top.MEM_ADDR_W;
        shadow = new[1 << mem_aw];
        repeat (10) @(posedge clk);
        rst_n <= 1'b1;
        reset_done = 1'b1;

        repeat (N_RESET_BUB) drive_bubble("reset");

        for (int i = 0; i < ALU_RPT; i++) begin
            for (int o = 0; o < 8; o++) begin
                for (int s = 0; s < 2; s++) begin
                    drive_instr("alu_ops", 1'b0, 1'b0, 1'b1, 1'b0, 1'b0, s[0], alu_op_t'(o),
                                WB_ALU, rand_reg(), rand_word(), rand_word(), rand_word(),
                                rand_word());
                end
            end
        end

        for (int i = 0; i < N_FILL; i++) begin
            addr = $random(seed) & ((1 << mem_aw) - 1);
            fill_list.push_back(addr);
            drive_mem_op("mem_fill", 1'b1, addr, rand_word());
        end
        for (int i = 0; i < N_LOAD; i++) begin
            addr = $random(seed) & ((1 << mem_aw) - 1);
            addr = fill_list[addr % N_FILL];  // one of the filled words
            drive_mem_op("mem_load", 1'b0, addr, 16'h0);
        end
        for (int i = 0; i < N_PAIR; i++) begin
            addr = $random(seed) & ((1 << mem_aw) - 1);
            drive_mem_op("store_load", 1'b1, addr, rand_word());
            drive_mem_op("store_load", 1'b0, addr, 16'h0);  // reads the word just stored
        end

        for (int i = 0; i < N_WB_OTHER / 2; i++) begin
            drive_instr("wb_pc", 1'b0, 1'b0, 1'b1, 1'b0, 1'b0, rand_bit(), rand_op(), WB_PC,
                        rand_reg(), rand_word(), rand_word(), rand_word(), rand_word());
            drive_instr("wb_imm", 1'b0, 1'b0, 1'b1, 1'b0, 1'b0, rand_bit(), rand_op(), WB_IMM,
                        rand_reg(), rand_word(), rand_word(), rand_word(), rand_word());
        end

        for (int i = 0; i < N_FLAGS; i++) begin
            drive_instr("flags", 1'b0, 1'b0, rand_bit(), rand_bit(), rand_bit(), rand_bit(),
                        rand_op(), WB_ALU, rand_reg(), rand_word(), rand_word(), rand_word(),
                        rand_word());
        end

        repeat (LAG - 1) drive_bubble("drain");
        @(posedge clk);

        $display("Test passed");
        $finish;
    end

endmodule
